//--- Makefile
TOP = tb_chip_select

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- hdl/chip_select.sv
// chip select top level joining the 68000 and z80 decoders
`default_nettype none

module chip_select (
    input  logic                                  clk_sys,
    input  logic                                  rst_n,
    input  logic [chip_select_pkg::pcb_w-1:0]       pcb,
    input  logic [chip_select_pkg::m68k_addr_w-1:0] m68k_a,
    input  logic                                  m68k_as_n,
    input  logic [chip_select_pkg::z80_addr_w-1:0]  z80_addr,
    input  logic                                  mreq_n,
    input  logic                                  iorq_n,
    // 68000 selects
    output logic                                  m68k_rom_cs,
    output logic                                  m68k_ram_cs,
    output logic                                  m68k_tile_pal_cs,
    output logic                                  m68k_txt_ram_cs,
    output logic                                  m68k_ram_2_cs,
    output logic                                  m68k_ram_3_cs,
    output logic                                  m68k_spr_cs,
    output logic                                  m68k_spr_pal_cs,
    output logic                                  m68k_fg_ram_cs,
    output logic                                  m68k_bg_ram_cs,
    output logic                                  input_p1_cs,
    output logic                                  input_p2_cs,
    output logic                                  input_dsw1_cs,
    output logic                                  input_dsw2_cs,
    output logic                                  irq_z80_cs,
    output logic                                  bg_scroll_x_cs,
    output logic                                  bg_scroll_y_cs,
    output logic                                  fg_scroll_x_cs,
    output logic                                  fg_scroll_y_cs,
    output logic                                  sound_latch_cs,
    output logic                                  irq_ack_cs,
    output logic                                  irq_i8751_cs,
    // z80 selects
    output logic                                  z80_rom_cs,
    output logic                                  z80_ram_cs,
    output logic                                  z80_sound0_cs,
    output logic                                  z80_sound1_cs,
    output logic                                  z80_dac1_cs,
    output logic                                  z80_dac2_cs,
    output logic                                  z80_latch_clr_cs,
    output logic                                  z80_latch_r_cs
);

    // main cpu map, port names match the top level one to one
    m68k_decoder u_m68k (
        .*
    );

    // sound cpu map
    z80_decoder u_z80 (
        .*
    );

endmodule : chip_select

`default_nettype wire

//--- hdl/chip_select_pkg.sv
// board codes, bus widths, z80 split points and port numbers, z80 address union
`default_nettype none

package chip_select_pkg;

    // bus widths
    localparam int m68k_addr_w = 24;
    localparam int z80_addr_w  = 16;
    localparam int pcb_w       = 4;

    // board codes, the gaps are boards this decoder does not map
    localparam logic [pcb_w-1:0] pcb_terraf   = 4'd0;
    localparam logic [pcb_w-1:0] pcb_armedf   = 4'd2;
    localparam logic [pcb_w-1:0] pcb_bigfghtr = 4'd3;
    localparam logic [pcb_w-1:0] pcb_legion   = 4'd5;

    // z80 rom/ram split points
    localparam logic [z80_addr_w-1:0] z80_ram_base_hi = 16'hf800; // terraf, armedf, bigfghtr
    localparam logic [z80_addr_w-1:0] z80_ram_base_lo = 16'hc000; // legion

    // z80 i/o port numbers, matched on the low address byte
    localparam logic [7:0] z80_port_sound0    = 8'h00; // ym3812 address
    localparam logic [7:0] z80_port_sound1    = 8'h01; // ym3812 data
    localparam logic [7:0] z80_port_dac1      = 8'h02;
    localparam logic [7:0] z80_port_dac2      = 8'h03;
    localparam logic [7:0] z80_port_latch_clr = 8'h04;
    localparam logic [7:0] z80_port_latch_r   = 8'h06;

    // select counts
    localparam int m68k_sel_n = 22;
    localparam int z80_io_n   = 6;

    // i/o cycles put the port on the low byte, the high byte is don't care
    typedef struct packed {
        logic [7:0] page;
        logic [7:0] port;
    } z80_io_addr_t;

    // one z80 address word, seen as a memory address or as page plus port
    typedef union packed {
        logic [z80_addr_w-1:0] mem;
        z80_io_addr_t          io;
    } z80_addr_u;

endpackage : chip_select_pkg

`default_nettype wire

//--- hdl/m68k_decoder.sv
// 68000 memory map decoder for terraf, armedf, bigfghtr and legion with registered selects
`default_nettype none

module m68k_decoder (
    input  logic                                  clk_sys,
    input  logic                                  rst_n,
    input  logic [chip_select_pkg::pcb_w-1:0]       pcb,
    input  logic [chip_select_pkg::m68k_addr_w-1:0] m68k_a,
    input  logic                                  m68k_as_n,
    output logic                                  m68k_rom_cs,
    output logic                                  m68k_ram_cs,
    output logic                                  m68k_tile_pal_cs,
    output logic                                  m68k_txt_ram_cs,
    output logic                                  m68k_ram_2_cs,
    output logic                                  m68k_ram_3_cs,
    output logic                                  m68k_spr_cs,
    output logic                                  m68k_spr_pal_cs,
    output logic                                  m68k_fg_ram_cs,
    output logic                                  m68k_bg_ram_cs,
    output logic                                  input_p1_cs,
    output logic                                  input_p2_cs,
    output logic                                  input_dsw1_cs,
    output logic                                  input_dsw2_cs,
    output logic                                  irq_z80_cs,
    output logic                                  bg_scroll_x_cs,
    output logic                                  bg_scroll_y_cs,
    output logic                                  fg_scroll_x_cs,
    output logic                                  fg_scroll_y_cs,
    output logic                                  sound_latch_cs,
    output logic                                  irq_ack_cs,
    output logic                                  irq_i8751_cs
);

    import chip_select_pkg::*;

    // terraf map, armedf shares rom, spr, ram and txt_ram with it
    localparam logic [m68k_addr_w-1:0]
        rom_lo         = 24'h000000,
        tf_rom_hi      = 24'h05ffff,
        tf_spr_lo      = 24'h060000,
        tf_spr_hi      = 24'h0603ff,
        tf_ram_lo      = 24'h060400,
        tf_ram_hi      = 24'h063fff,
        tf_tile_pal_lo = 24'h064000,
        tf_tile_pal_hi = 24'h064fff,
        tf_txt_lo      = 24'h068000,
        tf_txt_hi      = 24'h069fff,
        tf_ram_2_lo    = 24'h06a000,
        tf_ram_2_hi    = 24'h06afff,
        tf_spr_pal_lo  = 24'h06c000,
        tf_spr_pal_hi  = 24'h06cfff,
        tf_fg_lo       = 24'h070000,
        tf_fg_hi       = 24'h070fff,
        tf_bg_lo       = 24'h074000,
        tf_bg_hi       = 24'h074fff,
        tf_in_base     = 24'h078000,
        tf_ctl_base    = 24'h07c000;

    // legion differs from terraf in the low map and swaps ram_2 for ram_3
    localparam logic [m68k_addr_w-1:0]
        lg_rom_hi      = 24'h03ffff,
        lg_spr_hi      = 24'h060fff,
        lg_ram_lo      = 24'h061000,
        lg_ram_3_lo    = 24'h06a000,
        lg_ram_3_hi    = 24'h06a9ff;

    // armedf upper map, bigfghtr runs the same layout one shift higher
    localparam logic [m68k_addr_w-1:0]
        af_ram_2_lo    = 24'h064000,
        af_ram_2_hi    = 24'h065fff,
        af_bg_lo       = 24'h066000,
        af_bg_hi       = 24'h066fff,
        af_fg_lo       = 24'h067000,
        af_fg_hi       = 24'h067fff,
        af_tile_pal_lo = 24'h06a000,
        af_tile_pal_hi = 24'h06afff,
        af_spr_pal_lo  = 24'h06b000,
        af_spr_pal_hi  = 24'h06bfff,
        af_in_base     = 24'h06c000,
        af_ram_3_lo    = 24'h06c008,
        af_ram_3_hi    = 24'h06c7ff,
        af_ctl_base    = 24'h06d000,
        bf_shift       = 24'h020000,
        bf_rom_hi      = 24'h07ffff,
        bf_spr_lo      = 24'h080000,
        bf_spr_hi      = 24'h0805ff,
        bf_ram_lo      = 24'h080600,
        bf_ram_hi      = 24'h083fff,
        bf_i8751       = 24'h400000;

    logic rom_d, ram_d, tile_pal_d, txt_ram_d, ram_2_d, ram_3_d;
    logic spr_d, spr_pal_d, fg_ram_d, bg_ram_d;
    logic p1_d, p2_d, dsw1_d, dsw2_d;
    logic irq_z80_d, bg_x_d, bg_y_d, fg_x_d, fg_y_d, latch_d, ack_d, i8751_d;

    logic                   board_ok;
    logic                   legion;
    logic                   big;
    logic                   has_fg;
    logic [m68k_addr_w-1:0] shift;
    logic [m68k_addr_w-1:0] in_base;
    logic [m68k_addr_w-1:0] ctl_base;

    logic [m68k_sel_n-1:0]  sel_d;
    logic [m68k_sel_n-1:0]  sel_q;

    function automatic logic in_rng(input logic [m68k_addr_w-1:0] a,
                                    input logic [m68k_addr_w-1:0] lo,
                                    input logic [m68k_addr_w-1:0] hi);
        return (a >= lo) && (a <= hi);
    endfunction

    // word wide register at an even address
    function automatic logic in_reg(input logic [m68k_addr_w-1:0] a,
                                    input logic [m68k_addr_w-1:0] lo);
        return in_rng(a, lo, lo + 24'd1);
    endfunction

    always_comb begin
        {rom_d, ram_d, tile_pal_d, txt_ram_d, ram_2_d, ram_3_d, spr_d, spr_pal_d,
         fg_ram_d, bg_ram_d, p1_d, p2_d, dsw1_d, dsw2_d, irq_z80_d, bg_x_d, bg_y_d,
         fg_x_d, fg_y_d, latch_d, ack_d, i8751_d} = '0;
        board_ok = 1'b0;
        legion   = 1'b0;
        big      = 1'b0;
        has_fg   = 1'b0;
        shift    = '0;
        in_base  = '0;
        ctl_base = '0;

        if (!m68k_as_n) begin
            case (pcb)
                pcb_terraf, pcb_legion: begin
                    board_ok   = 1'b1;
                    legion     = (pcb == pcb_legion);
                    in_base    = tf_in_base;
                    ctl_base   = tf_ctl_base;
                    rom_d      = in_rng(m68k_a, rom_lo, legion ? lg_rom_hi : tf_rom_hi);
                    spr_d      = in_rng(m68k_a, tf_spr_lo, legion ? lg_spr_hi : tf_spr_hi);
                    ram_d      = in_rng(m68k_a, legion ? lg_ram_lo : tf_ram_lo, tf_ram_hi);
                    tile_pal_d = in_rng(m68k_a, tf_tile_pal_lo, tf_tile_pal_hi);
                    txt_ram_d  = in_rng(m68k_a, tf_txt_lo, tf_txt_hi);
                    ram_2_d    = !legion && in_rng(m68k_a, tf_ram_2_lo, tf_ram_2_hi);
                    ram_3_d    = legion && in_rng(m68k_a, lg_ram_3_lo, lg_ram_3_hi);
                    spr_pal_d  = in_rng(m68k_a, tf_spr_pal_lo, tf_spr_pal_hi);
                    fg_ram_d   = in_rng(m68k_a, tf_fg_lo, tf_fg_hi);
                    bg_ram_d   = in_rng(m68k_a, tf_bg_lo, tf_bg_hi);
                end
                pcb_armedf, pcb_bigfghtr: begin
                    board_ok   = 1'b1;
                    has_fg     = 1'b1;
                    big        = (pcb == pcb_bigfghtr);
                    shift      = big ? bf_shift : '0;
                    in_base    = af_in_base + shift;
                    ctl_base   = af_ctl_base + shift;
                    rom_d      = in_rng(m68k_a, rom_lo, big ? bf_rom_hi : tf_rom_hi);
                    spr_d      = in_rng(m68k_a, big ? bf_spr_lo : tf_spr_lo,
                                        big ? bf_spr_hi : tf_spr_hi);
                    ram_d      = in_rng(m68k_a, big ? bf_ram_lo : tf_ram_lo,
                                        big ? bf_ram_hi : tf_ram_hi);
                    ram_2_d    = in_rng(m68k_a, af_ram_2_lo + shift, af_ram_2_hi + shift);
                    bg_ram_d   = in_rng(m68k_a, af_bg_lo + shift, af_bg_hi + shift);
                    fg_ram_d   = in_rng(m68k_a, af_fg_lo + shift, af_fg_hi + shift);
                    txt_ram_d  = in_rng(m68k_a, tf_txt_lo + shift, tf_txt_hi + shift);
                    tile_pal_d = in_rng(m68k_a, af_tile_pal_lo + shift, af_tile_pal_hi + shift);
                    spr_pal_d  = in_rng(m68k_a, af_spr_pal_lo + shift, af_spr_pal_hi + shift);
                    ram_3_d    = !big && in_rng(m68k_a, af_ram_3_lo, af_ram_3_hi);
                    i8751_d    = big && in_reg(m68k_a, bf_i8751); // mcu interrupt
                end
                default: ; // unmapped board, nothing selected
            endcase
        end

        // short registers sit at the same offsets on every board
        if (board_ok) begin
            p1_d      = in_reg(m68k_a, in_base);
            p2_d      = in_reg(m68k_a, in_base + 24'h2);
            dsw1_d    = in_reg(m68k_a, in_base + 24'h4);
            dsw2_d    = in_reg(m68k_a, in_base + 24'h6);
            irq_z80_d = in_reg(m68k_a, ctl_base);
            bg_x_d    = in_reg(m68k_a, ctl_base + 24'h2);
            bg_y_d    = in_reg(m68k_a, ctl_base + 24'h4);
            fg_x_d    = has_fg && in_reg(m68k_a, ctl_base + 24'h6);
            fg_y_d    = has_fg && in_reg(m68k_a, ctl_base + 24'h8);
            latch_d   = in_reg(m68k_a, ctl_base + 24'ha); // sound latch write
            ack_d     = in_reg(m68k_a, ctl_base + 24'he);
        end
    end

    assign sel_d = {rom_d, ram_d, tile_pal_d, txt_ram_d, ram_2_d, ram_3_d, spr_d, spr_pal_d,
                    fg_ram_d, bg_ram_d, p1_d, p2_d, dsw1_d, dsw2_d, irq_z80_d, bg_x_d, bg_y_d,
                    fg_x_d, fg_y_d, latch_d, ack_d, i8751_d};

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else begin
            sel_q <= sel_d; // one cycle decode latency
        end
    end

    assign {m68k_rom_cs, m68k_ram_cs, m68k_tile_pal_cs, m68k_txt_ram_cs, m68k_ram_2_cs,
            m68k_ram_3_cs, m68k_spr_cs, m68k_spr_pal_cs, m68k_fg_ram_cs, m68k_bg_ram_cs,
            input_p1_cs, input_p2_cs, input_dsw1_cs, input_dsw2_cs, irq_z80_cs,
            bg_scroll_x_cs, bg_scroll_y_cs, fg_scroll_x_cs, fg_scroll_y_cs,
            sound_latch_cs, irq_ack_cs, irq_i8751_cs} = sel_q;

    // regions of a board never overlap
    a_m68k_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $onehot0(sel_q));

    // an idle bus cycle leaves every select low on the next cycle
    a_m68k_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $past(m68k_as_n) |-> (sel_q == '0));

endmodule : m68k_decoder

`default_nettype wire

//--- hdl/z80_decoder.sv
// z80 rom/ram split and i/o port decoder with registered selects
`default_nettype none

module z80_decoder (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  logic [chip_select_pkg::pcb_w-1:0]      pcb,
    input  logic [chip_select_pkg::z80_addr_w-1:0] z80_addr,
    input  logic                                 mreq_n,
    input  logic                                 iorq_n,
    output logic                                 z80_rom_cs,
    output logic                                 z80_ram_cs,
    output logic                                 z80_sound0_cs,
    output logic                                 z80_sound1_cs,
    output logic                                 z80_dac1_cs,
    output logic                                 z80_dac2_cs,
    output logic                                 z80_latch_clr_cs,
    output logic                                 z80_latch_r_cs
);

    import chip_select_pkg::*;

    z80_addr_u             addr;
    logic [z80_addr_w-1:0] split;
    logic                  board_ok;
    logic                  mem_cyc;
    logic                  io_cyc;
    logic [z80_io_n+1:0]   sel_d; // {rom, ram, ports}
    logic [z80_io_n+1:0]   sel_q;

    assign addr = z80_addr;

    always_comb begin
        board_ok = 1'b1;
        case (pcb)
            pcb_legion: split = z80_ram_base_lo;
            pcb_terraf, pcb_armedf, pcb_bigfghtr: split = z80_ram_base_hi;
            default: begin
                split    = z80_ram_base_hi;
                board_ok = 1'b0; // unmapped board
            end
        endcase
    end

    assign mem_cyc = board_ok && !mreq_n;
    assign io_cyc  = board_ok && !iorq_n;

    assign sel_d[z80_io_n+1] = mem_cyc && (addr.mem <  split);
    assign sel_d[z80_io_n]   = mem_cyc && (addr.mem >= split);
    // page byte ignored, only the port byte is decoded
    assign sel_d[0] = io_cyc && (addr.io.port == z80_port_sound0);
    assign sel_d[1] = io_cyc && (addr.io.port == z80_port_sound1);
    assign sel_d[2] = io_cyc && (addr.io.port == z80_port_dac1);
    assign sel_d[3] = io_cyc && (addr.io.port == z80_port_dac2);
    assign sel_d[4] = io_cyc && (addr.io.port == z80_port_latch_clr);
    assign sel_d[5] = io_cyc && (addr.io.port == z80_port_latch_r);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else begin
            sel_q <= sel_d;
        end
    end

    assign {z80_rom_cs, z80_ram_cs, z80_latch_r_cs, z80_latch_clr_cs, z80_dac2_cs,
            z80_dac1_cs, z80_sound1_cs, z80_sound0_cs} = sel_q;

    a_z80_mem_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !(z80_rom_cs && z80_ram_cs));

    a_z80_io_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $onehot0(sel_q[z80_io_n-1:0]));

endmodule : z80_decoder

`default_nettype wire

//--- tests/cs_model.svh
// expected 68000 and z80 select functions with the testbench copy of the memory maps
`ifndef cs_model_svh
`define cs_model_svh

// bounds of select k (port order) on a board, ok low where the board has no such select
function automatic void m68k_region(input logic [pcb_w-1:0] board, input int k,
                                    output logic ok,
                                    output logic [m68k_addr_w-1:0] lo,
                                    output logic [m68k_addr_w-1:0] hi);
    logic                   lg;
    logic                   big;
    logic                   af;
    logic [m68k_addr_w-1:0] sh;
    logic [m68k_addr_w-1:0] ib;
    logic [m68k_addr_w-1:0] cb;
    lg  = (board == 4'd5);
    big = (board == 4'd3);
    af  = (board == 4'd2) || big; // armedf layout
    sh  = big ? 24'h020000 : 24'h000000;
    ib  = af ? 24'h06c000 + sh : 24'h078000; // inputs
    cb  = af ? 24'h06d000 + sh : 24'h07c000; // control registers
    ok  = af || lg || (board == 4'd0);
    lo  = '0;
    hi  = '0;
    case (k)
        0: {lo, hi} = {24'h000000, lg ? 24'h03ffff : (big ? 24'h07ffff : 24'h05ffff)};
        1: {lo, hi} = {big ? 24'h080600 : (lg ? 24'h061000 : 24'h060400),
                       big ? 24'h083fff : 24'h063fff};
        2: {lo, hi} = af ? {24'h06a000 + sh, 24'h06afff + sh} : {24'h064000, 24'h064fff};
        3: {lo, hi} = {24'h068000 + sh, 24'h069fff + sh};
        4: {lo, hi} = af ? {24'h064000 + sh, 24'h065fff + sh} : {24'h06a000, 24'h06afff};
        5: {lo, hi} = lg ? {24'h06a000, 24'h06a9ff} : {24'h06c008, 24'h06c7ff};
        6: {lo, hi} = {big ? 24'h080000 : 24'h060000,
                       lg ? 24'h060fff : (big ? 24'h0805ff : 24'h0603ff)};
        7: {lo, hi} = af ? {24'h06b000 + sh, 24'h06bfff + sh} : {24'h06c000, 24'h06cfff};
        8: {lo, hi} = af ? {24'h067000 + sh, 24'h067fff + sh} : {24'h070000, 24'h070fff};
        9: {lo, hi} = af ? {24'h066000 + sh, 24'h066fff + sh} : {24'h074000, 24'h074fff};
        10, 11, 12, 13: lo = ib + 24'(2 * (k - 10)); // p1, p2, dsw1, dsw2
        14, 15, 16, 17, 18, 19: lo = cb + 24'(2 * (k - 14));
        20: lo = cb + 24'h00000e; // irq ack
        21: lo = 24'h400000; // i8751 irq
        default: ok = 1'b0;
    endcase
    if (k >= 10) begin
        hi = lo + 24'd1; // word registers
    end
    if ((k == 4 && lg) || (k == 5 && !lg && board != 4'd2) ||
        ((k == 17 || k == 18) && !af) || (k == 21 && !big)) begin
        ok = 1'b0;
    end
endfunction

function automatic logic [m68k_sel_n-1:0] m68k_expect(input logic [pcb_w-1:0] board,
                                                      input logic [m68k_addr_w-1:0] a,
                                                      input logic as_n);
    logic [m68k_sel_n-1:0]  s;
    logic                   ok;
    logic [m68k_addr_w-1:0] lo;
    logic [m68k_addr_w-1:0] hi;
    s = '0;
    for (int k = 0; k < m68k_sel_n; k++) begin
        m68k_region(board, k, ok, lo, hi);
        s[m68k_sel_n-1-k] = ok && !as_n && (a >= lo) && (a <= hi);
    end
    return s;
endfunction

// {rom, ram, sound0, sound1, dac1, dac2, latch_clr, latch_r}
function automatic logic [z80_io_n+1:0] z80_expect(input logic [pcb_w-1:0] board,
                                                   input logic [z80_addr_w-1:0] a,
                                                   input logic mreq, input logic iorq);
    logic                  kept;
    logic                  mem;
    logic                  io;
    logic [z80_addr_w-1:0] split;
    logic [7:0]            port;
    kept  = (board == 4'd0) || (board == 4'd2) || (board == 4'd3) || (board == 4'd5);
    split = (board == 4'd5) ? 16'hc000 : 16'hf800;
    mem   = kept && !mreq;
    io    = kept && !iorq;
    port  = a[7:0]; // page byte plays no part
    return {mem && (a < split), mem && (a >= split), io && (port == 8'h00),
            io && (port == 8'h01), io && (port == 8'h02), io && (port == 8'h03),
            io && (port == 8'h04), io && (port == 8'h06)};
endfunction

`endif

//--- tests/tb_chip_select.sv
// testbench for chip_select with random stimulus, reference model and timeout
`default_nettype none

module tb_chip_select;

    timeunit 1ns;
    timeprecision 1ns;

    import chip_select_pkg::*;

    `include "cs_model.svh"

    localparam int board_cycles = 400;
    localparam int max_cycles   = 5 * board_cycles + 500;

    logic                   clk_sys;
    logic                   rst_n;
    logic [pcb_w-1:0]       pcb;
    logic [m68k_addr_w-1:0] m68k_a;
    logic                   m68k_as_n;
    logic [z80_addr_w-1:0]  z80_addr;
    logic                   mreq_n;
    logic                   iorq_n;
    logic m68k_rom_cs, m68k_ram_cs, m68k_tile_pal_cs, m68k_txt_ram_cs, m68k_ram_2_cs;
    logic m68k_ram_3_cs, m68k_spr_cs, m68k_spr_pal_cs, m68k_fg_ram_cs, m68k_bg_ram_cs;
    logic input_p1_cs, input_p2_cs, input_dsw1_cs, input_dsw2_cs, irq_z80_cs;
    logic bg_scroll_x_cs, bg_scroll_y_cs, fg_scroll_x_cs, fg_scroll_y_cs;
    logic sound_latch_cs, irq_ack_cs, irq_i8751_cs;
    logic z80_rom_cs, z80_ram_cs, z80_sound0_cs, z80_sound1_cs;
    logic z80_dac1_cs, z80_dac2_cs, z80_latch_clr_cs, z80_latch_r_cs;

    logic [m68k_sel_n-1:0] m68k_act;
    logic [z80_io_n+1:0]   z80_act;
    int                    cycles = 0;
    logic [pcb_w-1:0]      boards [5] = '{4'd0, 4'd2, 4'd3, 4'd5, 4'd6}; // 6 is unmapped

    string m68k_names [m68k_sel_n] = '{"m68k_rom_cs", "m68k_ram_cs", "m68k_tile_pal_cs",
        "m68k_txt_ram_cs", "m68k_ram_2_cs", "m68k_ram_3_cs", "m68k_spr_cs", "m68k_spr_pal_cs",
        "m68k_fg_ram_cs", "m68k_bg_ram_cs", "input_p1_cs", "input_p2_cs", "input_dsw1_cs",
        "input_dsw2_cs", "irq_z80_cs", "bg_scroll_x_cs", "bg_scroll_y_cs", "fg_scroll_x_cs",
        "fg_scroll_y_cs", "sound_latch_cs", "irq_ack_cs", "irq_i8751_cs"};
    string z80_names [z80_io_n+2] = '{"z80_rom_cs", "z80_ram_cs", "z80_sound0_cs",
        "z80_sound1_cs", "z80_dac1_cs", "z80_dac2_cs", "z80_latch_clr_cs", "z80_latch_r_cs"};

    chip_select u_dut (
        .*
    );

    assign m68k_act = {m68k_rom_cs, m68k_ram_cs, m68k_tile_pal_cs, m68k_txt_ram_cs,
                       m68k_ram_2_cs, m68k_ram_3_cs, m68k_spr_cs, m68k_spr_pal_cs,
                       m68k_fg_ram_cs, m68k_bg_ram_cs, input_p1_cs, input_p2_cs,
                       input_dsw1_cs, input_dsw2_cs, irq_z80_cs, bg_scroll_x_cs,
                       bg_scroll_y_cs, fg_scroll_x_cs, fg_scroll_y_cs, sound_latch_cs,
                       irq_ack_cs, irq_i8751_cs};
    assign z80_act = {z80_rom_cs, z80_ram_cs, z80_sound0_cs, z80_sound1_cs, z80_dac1_cs,
                      z80_dac2_cs, z80_latch_clr_cs, z80_latch_r_cs};

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles without reaching the end of the tests", cycles);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_m68k_sel(input logic [m68k_sel_n-1:0] exp,
                                  input logic [m68k_sel_n-1:0] act);
        int bad;
        bad = -1;
        for (int k = m68k_sel_n - 1; k >= 0; k--) begin
            if (exp[m68k_sel_n-1-k] !== act[m68k_sel_n-1-k]) begin
                bad = k; // lowest port index wins
            end
        end
        if (bad >= 0) begin
            $display("[ERROR] at %0t ns %s expected %0b actual %0b", $time, m68k_names[bad],
                     exp[m68k_sel_n-1-bad], act[m68k_sel_n-1-bad]);
            $display("Checks failed");
            $fatal(1, "68000 select mismatch");
        end
    endtask

    task automatic check_z80_sel(input logic [z80_io_n+1:0] exp,
                                 input logic [z80_io_n+1:0] act);
        int bad;
        bad = -1;
        for (int k = z80_io_n + 1; k >= 0; k--) begin
            if (exp[z80_io_n+1-k] !== act[z80_io_n+1-k]) begin
                bad = k;
            end
        end
        if (bad >= 0) begin
            $display("[ERROR] at %0t ns %s expected %0b actual %0b", $time, z80_names[bad],
                     exp[z80_io_n+1-bad], act[z80_io_n+1-bad]);
            $display("Checks failed");
            $fatal(1, "z80 select mismatch");
        end
    endtask

    // outputs now show the decode of the inputs held over the last edge
    task automatic check_outputs();
        check_m68k_sel(m68k_expect(pcb, m68k_a, m68k_as_n), m68k_act);
        check_z80_sel(z80_expect(pcb, z80_addr, mreq_n, iorq_n), z80_act);
    endtask

    task automatic drive_inputs(input logic [pcb_w-1:0] board);
        logic                   ok;
        logic [m68k_addr_w-1:0] lo;
        logic [m68k_addr_w-1:0] hi;
        int                     r;
        int                     cyc;
        r = int'($urandom % 4);
        m68k_region(board, int'($urandom % m68k_sel_n), ok, lo, hi);
        pcb       = board;
        m68k_as_n = ($urandom % 8) == 0;
        if (r == 3 && ok) begin
            m68k_a = (($urandom % 2) != 0) ? lo : hi; // region edges
        end else if (r == 2 && ok) begin
            m68k_a = lo + 24'($urandom % (32'(hi - lo) + 1));
        end else if (r == 1) begin
            m68k_a = 24'h060000 + 24'($urandom % 32'h30000); // dense part of the maps
        end else begin
            m68k_a = 24'($urandom);
        end
        cyc    = int'($urandom % 3);
        mreq_n = (cyc != 0);
        iorq_n = (cyc != 1);
        z80_addr = 16'($urandom);
        if (($urandom % 2) != 0) begin
            z80_addr[7:0] = 8'($urandom % 8); // ports 00 to 07
        end
        if (($urandom % 2) != 0) begin
            z80_addr[15:11] = (($urandom % 2) != 0) ? 5'h17 + 5'($urandom % 2)
                                                    : 5'h1e + 5'($urandom % 2);
        end
    endtask

    initial begin
        void'($urandom(32'h6c75));
        rst_n     = 1'b0;
        pcb       = '0;
        m68k_a    = 24'h000100; // rom cycles on both buses while reset is held
        m68k_as_n = 1'b0;
        z80_addr  = 16'h0100;
        mreq_n    = 1'b0;
        iorq_n    = 1'b1;
        repeat (3) begin
            @(posedge clk_sys);
            #1;
            check_m68k_sel('0, m68k_act);
            check_z80_sel('0, z80_act);
        end
        rst_n     = 1'b1;
        m68k_as_n = 1'b1; // first edge after reset sees idle buses
        mreq_n    = 1'b1;
        foreach (boards[b]) begin
            repeat (board_cycles) begin
                @(posedge clk_sys);
                #1;
                check_outputs();
                drive_inputs(boards[b]);
            end
        end
        @(posedge clk_sys);
        #1;
        check_outputs(); // last driven inputs
        $display("All checks passed");
        $finish;
    end

endmodule : tb_chip_select

`default_nettype wire

//--- verilog.f
+incdir+tests
hdl/chip_select_pkg.sv
hdl/m68k_decoder.sv
hdl/z80_decoder.sv
hdl/chip_select.sv
tests/tb_chip_select.sv
